/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_exec_top
FILELIST   := exec_top.f
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal --Mdir obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* exec_top.f */
+incdir+include
verilog/exec_pkg.sv
verilog/operand_if.sv
verilog/mul_pipe.sv
verilog/div_seq.sv
verilog/stall_ctrl.sv
verilog/alu.sv
verilog/exec_top.sv
test/tb_exec_top.sv

/* include/alu_ref.svh */
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected result word of one operation
function automatic logic [exec_pkg::XLEN-1:0] alu_ref(
  input exec_pkg::alu_op_t         op,
  input logic [exec_pkg::XLEN-1:0] a,
  input logic [exec_pkg::XLEN-1:0] b
);
  logic signed [2*exec_pkg::XLEN-1:0] prod;
  logic [4:0]                         sh;
  logic                               ovf;
  logic [exec_pkg::XLEN-1:0]          res;

  sh   = b[4:0];
  prod = longint'($signed(a)) * longint'($signed(b));
  ovf  = (a == {1'b1, {(exec_pkg::XLEN-1){1'b0}}}) && (b == '1);  // MIN / -1
  case (op)
    exec_pkg::ALU_AND:     res = a & b;
    exec_pkg::ALU_OR:      res = a | b;
    exec_pkg::ALU_XOR:     res = a ^ b;
    exec_pkg::ALU_ADD:     res = a + b;
    exec_pkg::ALU_SUB:     res = a - b;
    exec_pkg::ALU_SLL:     res = a << sh;
    exec_pkg::ALU_SRL:     res = a >> sh;
    exec_pkg::ALU_SRA:     res = $signed(a) >>> sh;
    exec_pkg::ALU_SRA_IMM: res = $signed(a) >>> sh;
    exec_pkg::ALU_SLTU:    res = (a < b) ? 1 : 0;
    exec_pkg::ALU_SLT:     res = ($signed(a) < $signed(b)) ? 1 : 0;
    exec_pkg::ALU_EQ:      res = (a == b) ? 1 : 0;
    exec_pkg::ALU_MUL:     res = prod[exec_pkg::XLEN-1:0];
    exec_pkg::ALU_MULH:    res = prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
    exec_pkg::ALU_DIV: begin
      if (b == '0) res = '1;
      else if (ovf) res = a;
      else res = $signed(a) / $signed(b);
    end
    exec_pkg::ALU_DIVU:    res = (b == '0) ? '1 : a / b;
    exec_pkg::ALU_REM: begin
      if (b == '0) res = a;
      else if (ovf) res = '0;
      else res = $signed(a) % $signed(b);
    end
    exec_pkg::ALU_REMU:    res = (b == '0) ? a : a % b;
    default:               res = a + b;
  endcase
  return res;
endfunction

// Expected stall length in cycles (0 for single-cycle ops)
function automatic int alu_ref_lat(input exec_pkg::alu_op_t op);
  case (op)
    exec_pkg::ALU_MUL, exec_pkg::ALU_MULH: return exec_pkg::MUL_LAT;
    exec_pkg::ALU_DIV, exec_pkg::ALU_DIVU,
    exec_pkg::ALU_REM, exec_pkg::ALU_REMU: return exec_pkg::DIV_LAT;
    default:                               return 0;
  endcase
endfunction

`endif

/* test/tb_exec_top.sv */
`timescale 1ns/10ps

module tb_exec_top;

  `include "alu_ref.svh"

  localparam int RESET_CYCLES = 16;
  localparam int RAND_OPS     = 2000;
  localparam int DIRECTED_OPS = 750;
  localparam int MAX_CYCLES   = 3 * (RAND_OPS * (exec_pkg::DIV_LAT + 1)
                                + DIRECTED_OPS * (exec_pkg::DIV_LAT + 1) + RESET_CYCLES) / 2;

  localparam logic [exec_pkg::XLEN-1:0] CORNER [6] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
    32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678
  };
  localparam exec_pkg::alu_op_t LOGIC_OPS [8] = '{
    exec_pkg::ALU_AND, exec_pkg::ALU_OR, exec_pkg::ALU_XOR, exec_pkg::ALU_ADD,
    exec_pkg::ALU_SUB, exec_pkg::ALU_SLTU, exec_pkg::ALU_SLT, exec_pkg::ALU_EQ
  };
  localparam exec_pkg::alu_op_t SHIFT_OPS [4] = '{
    exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA, exec_pkg::ALU_SRA_IMM
  };
  localparam exec_pkg::alu_op_t DIV_OPS [4] = '{
    exec_pkg::ALU_DIV, exec_pkg::ALU_DIVU, exec_pkg::ALU_REM, exec_pkg::ALU_REMU
  };

  logic                      clk;
  logic                      rst;
  logic [exec_pkg::XLEN-1:0] left_operand;
  logic [exec_pkg::XLEN-1:0] right_operand;
  exec_pkg::alu_op_t         alu_op;
  logic [exec_pkg::XLEN-1:0] alu_res;
  logic                      insert_bubble;

  logic pending;  // Op presented, result not yet seen
  int   stall_cycles;
  int   cycles = 0;
  int   checks;
  int   errors;
  int   test_ops;
  int   errors_before;
  int   num_tests;
  event result_done;

  exec_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .left_operand (left_operand),
    .right_operand(right_operand),
    .alu_op       (alu_op),
    .alu_res      (alu_res),
    .insert_bubble(insert_bubble)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished the current op", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [exec_pkg::XLEN-1:0] got,
                             input logic [exec_pkg::XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Mid-cycle sample, inputs and result settled by now
  always @(negedge clk) begin
    if (pending) begin
      if (insert_bubble) begin
        stall_cycles++;
      end else begin
        check_value($sformatf("%s %h %h", alu_op.name(), left_operand, right_operand),
                    alu_res, alu_ref(alu_op, left_operand, right_operand));
        if (stall_cycles != alu_ref_lat(alu_op)) begin
          errors++;
          $display("error at %0t: %s stalled for %0d cycles instead of %0d",
                   $time, alu_op.name(), stall_cycles, alu_ref_lat(alu_op));
        end
        pending = 1'b0;
        ->result_done;
      end
    end
  end

  // Present one op and hold it until its result cycle
  task automatic run_op(input exec_pkg::alu_op_t op, input logic [exec_pkg::XLEN-1:0] a,
                        input logic [exec_pkg::XLEN-1:0] b);
    @(posedge clk);
    alu_op        <= op;
    left_operand  <= a;
    right_operand <= b;
    stall_cycles  = 0;
    pending       = 1'b1;
    @(result_done);
    test_ops++;
  endtask

  task automatic start_test();
    test_ops      = 0;
    errors_before = errors;
  endtask

  task automatic report_test(input string name);
    num_tests++;
    $display("%s: %0d ops, %0d errors", name, test_ops, errors - errors_before);
  endtask

  initial begin
    exec_pkg::alu_op_t         op;
    logic [exec_pkg::XLEN-1:0] a;
    logic [exec_pkg::XLEN-1:0] b;
    int                        sel;

    void'($urandom(32'h28d8));
    rst           = 1'b1;
    left_operand  = '0;
    right_operand = '0;
    alu_op        = exec_pkg::ALU_ADD;
    pending       = 1'b0;
    stall_cycles  = 0;
    checks        = 0;
    errors        = 0;
    num_tests     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (insert_bubble !== 1'b0) begin
      errors++;
      $display("error: insert_bubble is high right after reset");
    end

    start_test();
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 6; j++) begin
        for (int k = 0; k < 6; k++) begin
          run_op(LOGIC_OPS[i], CORNER[j], CORNER[k]);
        end
      end
      run_op(LOGIC_OPS[i], $urandom() | 32'h8000_0000, $urandom());
    end
    report_test("single-cycle ops");

    start_test();
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 32; s++) begin
        a = (s % 2 == 1) ? ($urandom() | 32'h8000_0000) : $urandom();
        b = ($urandom() & ~32'h1f) | 32'(s);  // Junk above the shift amount
        run_op(SHIFT_OPS[i], a, b);
      end
    end
    report_test("shifts");

    start_test();
    for (int j = 0; j < 6; j++) begin
      for (int k = 0; k < 6; k++) begin
        run_op(exec_pkg::ALU_MUL, CORNER[j], CORNER[k]);
        run_op(exec_pkg::ALU_MULH, CORNER[j], CORNER[k]);
      end
    end
    for (int n = 0; n < 20; n++) begin
      run_op(exec_pkg::ALU_MUL, $urandom(), $urandom());
      run_op(exec_pkg::ALU_MULH, $urandom(), $urandom());
    end
    report_test("multiply");

    start_test();
    for (int i = 0; i < 4; i++) begin
      // Corners cover divide by zero and MIN / -1
      for (int j = 0; j < 6; j++) begin
        for (int k = 0; k < 6; k++) begin
          run_op(DIV_OPS[i], CORNER[j], CORNER[k]);
        end
      end
      for (int n = 0; n < 10; n++) begin
        run_op(DIV_OPS[i], $urandom(), $urandom() >> $urandom_range(31, 0));
      end
    end
    report_test("divide");

    start_test();
    for (int n = 0; n < RAND_OPS; n++) begin
      op  = exec_pkg::alu_op_t'(5'($urandom_range(17, 0)));
      a   = $urandom();
      sel = $urandom_range(7, 0);
      if (sel == 0) begin
        b = '0;
      end else if (sel == 1) begin
        b = CORNER[$urandom_range(5, 0)];
      end else begin
        b = $urandom();
      end
      run_op(op, a, b);
    end
    report_test("random mix");

    $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [exec_pkg::XLEN-1:0] left_operand,
  input  logic [exec_pkg::XLEN-1:0] right_operand,
  input  exec_pkg::alu_op_t         alu_op,
  output logic [exec_pkg::XLEN-1:0] alu_res,
  output logic                      insert_bubble
);

  logic [2*exec_pkg::XLEN-1:0] mul_res;
  logic [exec_pkg::XLEN-1:0]   quot;
  logic [exec_pkg::XLEN-1:0]   rem;
  logic [4:0]                  shamt;
  logic                        is_mul;
  logic                        is_div;
  logic                        ctrl_idle;
  logic                        issue;
  logic                        start_mul;
  logic                        start_div;
  logic                        done;

  operand_if ops ();

  assign shamt = right_operand[4:0];  // RV32 shift amount

  assign is_mul = alu_op inside {exec_pkg::ALU_MUL, exec_pkg::ALU_MULH};
  assign is_div = alu_op inside {exec_pkg::ALU_DIV, exec_pkg::ALU_DIVU,
                                 exec_pkg::ALU_REM, exec_pkg::ALU_REMU};

  // Only the first cycle of a held multi-cycle op issues
  assign issue     = (is_mul | is_div) & ctrl_idle;
  assign start_mul = issue & is_mul;
  assign start_div = issue & is_div;

  // Cleared on issue, set again in the result cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_idle <= 1'b1;
    end else if (issue) begin
      ctrl_idle <= 1'b0;
    end else if (done) begin
      ctrl_idle <= 1'b1;
    end
  end

  assign ops.left  = left_operand;
  assign ops.right = right_operand;
  assign ops.op    = alu_op;
  assign ops.issue = issue;

  always_comb begin
    case (alu_op)
      exec_pkg::ALU_AND:     alu_res = left_operand & right_operand;
      exec_pkg::ALU_OR:      alu_res = left_operand | right_operand;
      exec_pkg::ALU_XOR:     alu_res = left_operand ^ right_operand;
      exec_pkg::ALU_ADD:     alu_res = left_operand + right_operand;
      exec_pkg::ALU_SUB:     alu_res = left_operand - right_operand;
      exec_pkg::ALU_SLL:     alu_res = left_operand << shamt;
      exec_pkg::ALU_SRL:     alu_res = left_operand >> shamt;
      exec_pkg::ALU_SRA:     alu_res = $signed(left_operand) >>> shamt;
      exec_pkg::ALU_SRA_IMM: alu_res = $signed(left_operand) >>> shamt;
      exec_pkg::ALU_SLTU: begin
        alu_res = {{(exec_pkg::XLEN-1){1'b0}}, left_operand < right_operand};
      end
      exec_pkg::ALU_SLT: begin
        alu_res = {{(exec_pkg::XLEN-1){1'b0}},
                   $signed(left_operand) < $signed(right_operand)};
      end
      exec_pkg::ALU_EQ: begin
        alu_res = {{(exec_pkg::XLEN-1){1'b0}}, left_operand == right_operand};
      end
      exec_pkg::ALU_MUL:     alu_res = mul_res[exec_pkg::XLEN-1:0];
      exec_pkg::ALU_MULH:    alu_res = mul_res[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
      exec_pkg::ALU_DIV:     alu_res = quot;
      exec_pkg::ALU_DIVU:    alu_res = quot;
      exec_pkg::ALU_REM:     alu_res = rem;
      exec_pkg::ALU_REMU:    alu_res = rem;
      default:               alu_res = left_operand + right_operand;
    endcase
  end

  mul_pipe mul_i (
    .clk    (clk),
    .ops    (ops.mul_side),
    .mul_res(mul_res)
  );

  div_seq div_i (
    .clk (clk),
    .rst (rst),
    .ops (ops.div_side),
    .quot(quot),
    .rem (rem)
  );

  stall_ctrl stall_i (
    .clk      (clk),
    .rst      (rst),
    .start_mul(start_mul),
    .start_div(start_div),
    .busy     (insert_bubble),
    .done     (done)
  );

endmodule

/* verilog/div_seq.sv */
`timescale 1ns/10ps

module div_seq (
  input  logic                      clk,
  input  logic                      rst,
  operand_if.div_side               ops,
  output logic [exec_pkg::XLEN-1:0] quot,
  output logic [exec_pkg::XLEN-1:0] rem
);

  localparam int W = exec_pkg::XLEN;

  logic             is_signed;
  logic             neg_a;
  logic             neg_b;
  logic [W-1:0]     mag_a;
  logic [W-1:0]     mag_b;
  logic [W-1:0]     part_rem;
  logic [W-1:0]     part_quo;
  logic [W-1:0]     divisor;
  logic             neg_quo;
  logic             neg_rem;
  logic             div_zero;
  logic [W-1:0]     step_rem_in;
  logic [W-1:0]     step_quo_in;
  logic [W-1:0]     step_div;
  logic [W:0]       shifted;
  logic [W:0]       diff;
  logic [W-1:0]     step_rem;
  logic [W-1:0]     step_quo;
  logic [exec_pkg::LAT_W-1:0] cnt;

  assign is_signed = ops.op inside {exec_pkg::ALU_DIV, exec_pkg::ALU_REM};
  assign neg_a     = is_signed & ops.left[W-1];
  assign neg_b     = is_signed & ops.right[W-1];
  assign mag_a     = neg_a ? -ops.left : ops.left;
  assign mag_b     = neg_b ? -ops.right : ops.right;

  // First step runs in the issue cycle straight from the magnitudes
  assign step_rem_in = ops.issue ? '0 : part_rem;
  assign step_quo_in = ops.issue ? mag_a : part_quo;
  assign step_div    = ops.issue ? mag_b : divisor;

  // Restoring shift-subtract step
  assign shifted  = {step_rem_in, step_quo_in[W-1]};
  assign diff     = shifted - {1'b0, step_div};
  assign step_rem = diff[W] ? shifted[W-1:0] : diff[W-1:0];
  assign step_quo = {step_quo_in[W-2:0], ~diff[W]};

  always_ff @(posedge clk) begin
    if (ops.issue || cnt > 1) begin
      part_rem <= step_rem;
      part_quo <= step_quo;
    end
    if (ops.issue) begin
      divisor  <= mag_b;
      div_zero <= ops.right == '0;
      neg_quo  <= neg_a ^ neg_b;
      neg_rem  <= neg_a;  // Remainder takes the dividend's sign
    end
  end

  // cnt counts the remaining steps and 1 is the fix-up cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      quot <= '0;
      rem  <= '0;
    end else if (ops.issue) begin
      cnt <= exec_pkg::LAT_W'(exec_pkg::DIV_LAT - 1);
    end else if (cnt > 1) begin
      cnt <= cnt - 1'b1;
    end else if (cnt == 1) begin
      cnt <= '0;
      // MIN / -1 wraps back to MIN on its own
      if (div_zero) begin
        quot <= '1;
      end else begin
        quot <= neg_quo ? -part_quo : part_quo;
      end
      rem <= neg_rem ? -part_rem : part_rem;  // Dividend on divide by zero
    end
  end

endmodule

/* verilog/exec_pkg.sv */
package exec_pkg;

  localparam int XLEN = 32;

  // Multi-cycle latencies, issue cycle to result cycle
  localparam int MUL_LAT = 6;
  localparam int DIV_LAT = 33;  // 32 steps plus sign fix-up

  // Stall counter classes
  localparam int NUM_CLASSES = 2;
  localparam int MUL_CLASS = 0;
  localparam int DIV_CLASS = 1;
  localparam int CLASS_LAT [NUM_CLASSES] = '{MUL_LAT, DIV_LAT};
  localparam int LAT_W = $clog2(DIV_LAT + 1);

  typedef enum logic [4:0] {
    ALU_AND     = 5'd0,
    ALU_OR      = 5'd1,
    ALU_XOR     = 5'd2,
    ALU_ADD     = 5'd3,
    ALU_SUB     = 5'd4,
    // Shifts
    ALU_SLL     = 5'd5,
    ALU_SRL     = 5'd6,
    ALU_SRA     = 5'd7,
    ALU_SRA_IMM = 5'd8,
    // Compares, 0 or 1 in bit 0
    ALU_SLTU    = 5'd9,
    ALU_SLT     = 5'd10,
    ALU_EQ      = 5'd11,
    // Multiplier
    ALU_MUL     = 5'd12,
    ALU_MULH    = 5'd13,
    // Divider
    ALU_DIV     = 5'd14,
    ALU_DIVU    = 5'd15,
    ALU_REM     = 5'd16,
    ALU_REMU    = 5'd17
  } alu_op_t;

endpackage

/* verilog/exec_top.sv */
`timescale 1ns/10ps

module exec_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [exec_pkg::XLEN-1:0] left_operand,
  input  logic [exec_pkg::XLEN-1:0] right_operand,
  input  exec_pkg::alu_op_t         alu_op,
  output logic [exec_pkg::XLEN-1:0] alu_res,
  output logic                      insert_bubble
);

  alu alu_i (
    .clk          (clk),
    .rst          (rst),
    .left_operand (left_operand),
    .right_operand(right_operand),
    .alu_op       (alu_op),
    .alu_res      (alu_res),
    .insert_bubble(insert_bubble)
  );

endmodule

/* verilog/mul_pipe.sv */
`timescale 1ns/10ps

module mul_pipe (
  input  logic                        clk,
  operand_if.mul_side                 ops,
  output logic [2*exec_pkg::XLEN-1:0] mul_res
);

  localparam int STAGES = exec_pkg::MUL_LAT - 1;  // After the input register

  logic [exec_pkg::XLEN-1:0]          left_q;
  logic [exec_pkg::XLEN-1:0]          right_q;
  logic signed [2*exec_pkg::XLEN-1:0] left_ext;
  logic signed [2*exec_pkg::XLEN-1:0] right_ext;
  logic [2*exec_pkg::XLEN-1:0]        prod_q [STAGES];

  // Operands captured once per issue
  always_ff @(posedge clk) begin
    if (ops.issue) begin
      left_q  <= ops.left;
      right_q <= ops.right;
    end
  end

  // Signed by signed, so the high half is MULH
  assign left_ext  = {{exec_pkg::XLEN{left_q[exec_pkg::XLEN-1]}}, left_q};
  assign right_ext = {{exec_pkg::XLEN{right_q[exec_pkg::XLEN-1]}}, right_q};

  always_ff @(posedge clk) begin
    prod_q[0] <= left_ext * right_ext;
    for (int i = 1; i < STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];  // Retiming room for the multiplier
    end
  end

  assign mul_res = prod_q[STAGES-1];

endmodule

/* verilog/operand_if.sv */
`timescale 1ns/10ps

// Operands and issue strobe from the ALU to the multi-cycle units
interface operand_if;

  logic [exec_pkg::XLEN-1:0] left;
  logic [exec_pkg::XLEN-1:0] right;
  exec_pkg::alu_op_t         op;
  logic                      issue;  // One cycle per multi-cycle op

  modport alu_side (
    output left,
    output right,
    output op,
    output issue
  );

  modport mul_side (
    input left,
    input right,
    input op,
    input issue
  );

  modport div_side (
    input left,
    input right,
    input op,
    input issue
  );

endinterface

/* verilog/stall_ctrl.sv */
`timescale 1ns/10ps

module stall_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic start_mul,
  input  logic start_div,
  output logic busy,
  output logic done
);

  logic [exec_pkg::NUM_CLASSES-1:0] start;
  logic [exec_pkg::LAT_W-1:0]       cnt [exec_pkg::NUM_CLASSES];

  assign start[exec_pkg::MUL_CLASS] = start_mul;
  assign start[exec_pkg::DIV_CLASS] = start_div;

  // One down counter per latency class
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < exec_pkg::NUM_CLASSES; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < exec_pkg::NUM_CLASSES; i++) begin
        if (start[i]) begin
          cnt[i] <= exec_pkg::LAT_W'(exec_pkg::CLASS_LAT[i]);
        end else if (cnt[i] != '0) begin
          cnt[i] <= cnt[i] - 1'b1;
        end
      end
    end
  end

  // Count of 1 is the result cycle, bubble already low
  always_comb begin
    busy = |start;  // Stall starts in the issue cycle
    done = 1'b0;
    for (int i = 0; i < exec_pkg::NUM_CLASSES; i++) begin
      if (cnt[i] > exec_pkg::LAT_W'(1)) begin
        busy = 1'b1;
      end
      if (cnt[i] == exec_pkg::LAT_W'(1)) begin
        done = 1'b1;
      end
    end
  end

endmodule
